// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

	localparam int BUS_DATA_WIDTH = 32;
	localparam int BUS_ADDR_WIDTH = 3;

	typedef logic [BUS_DATA_WIDTH-1:0] bus_data_t;	// one bus word
	typedef logic [BUS_ADDR_WIDTH-1:0] bus_addr_t;	// word address, no byte lanes

	// master side of the wishbone classic port
	// stb, we, adr and dat stay put until ack comes back
	typedef struct packed {
		logic      stb;
		logic      we;
		bus_addr_t adr;
		bus_data_t dat;	// write data
	} wb_req_t;

	// slave side, ack lasts exactly one cycle
	typedef struct packed {
		logic      ack;
		bus_data_t dat;	// read data, valid with ack
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: common/timer_pkg.sv
`default_nettype none

package timer_pkg;

	localparam int COUNT_WIDTH_DEF = 32;	// default counter width
	localparam int DIV_SEL_WIDTH   = 3;
	localparam int DIV_CNT_WIDTH   = 7;	// holds the largest terminal count, 127

	typedef logic [COUNT_WIDTH_DEF-1:0] count_t;	// count, load and compare values
	typedef logic [DIV_SEL_WIDTH-1:0]   div_sel_t;	// tick every 2**div_sel clocks
	typedef logic [DIV_CNT_WIDTH-1:0]   div_cnt_t;	// prescaler divide counter

	// register map, word addresses
	localparam bus_pkg::bus_addr_t ADDR_TCSR  = 3'd0;	// control and status
	localparam bus_pkg::bus_addr_t ADDR_COUNT = 3'd1;	// live count, write loads
	localparam bus_pkg::bus_addr_t ADDR_CMP   = 3'd2;	// compare value

	// control/status word, low byte of ADDR_TCSR
	typedef struct packed {
		logic     isr;	// sticky flag, write one to clear
		div_sel_t div_sel;
		logic     rst_on_cmp;
		logic     int_en;
		logic     rsvd;	// always reads zero
		logic     enable;
	} tcsr_t;

	// everything the prescaler and counter need from the register block
	typedef struct packed {
		logic     enable;
		div_sel_t div_sel;
		logic     rst_on_cmp;
		logic     load_valid;	// one cycle pulse
		count_t   load_value;
		count_t   cmp_value;
	} timer_ctrl_t;

endpackage

`default_nettype wire

// File: flist.f
+incdir+test
common/bus_pkg.sv
common/timer_pkg.sv
timer/timer_regs.sv
timer/timer_prescaler.sv
timer/timer_counter.sv
hdl/timer_top.sv
test/tb_timer.sv

// File: hdl/timer_top.sv
`timescale 1ns/1ps
`default_nettype none

module timer_top #(
	parameter int COUNTER_WIDTH = timer_pkg::COUNT_WIDTH_DEF
) (
	input  wire                    clk,
	input  wire                    reset,
	input  wire bus_pkg::wb_req_t  bus_req_i,
	output wire bus_pkg::wb_rsp_t  bus_rsp_o,
	output wire                    irq_o
);

	import timer_pkg::*;

	timer_ctrl_t              ctrl;	// register block to datapath
	logic                     tick;
	logic [COUNTER_WIDTH-1:0] count;
	logic                     match;

	// bus decode, control fields, interrupt flag
	timer_regs #(
		.COUNTER_WIDTH (COUNTER_WIDTH)
	) u_regs (
		.clk       (clk),
		.reset     (reset),
		.bus_req_i (bus_req_i),
		.bus_rsp_o (bus_rsp_o),
		.count_i   (count),
		.match_i   (match),
		.ctrl_o    (ctrl),
		.irq_o     (irq_o)
	);

	// power of two clock divider
	timer_prescaler u_prescaler (
		.clk    (clk),
		.reset  (reset),
		.ctrl_i (ctrl),
		.tick_o (tick)
	);

	timer_counter #(
		.COUNTER_WIDTH (COUNTER_WIDTH)
	) u_counter (
		.clk     (clk),
		.reset   (reset),
		.ctrl_i  (ctrl),
		.tick_i  (tick),
		.count_o (count),
		.match_o (match)	// sets the interrupt flag
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the timer testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tb_timer \
	-f flist.f \
	--Mdir "$BUILD_DIR" \
	-o tb_timer_sim

# a failed check ends the run with a non-zero status
"./$BUILD_DIR/tb_timer_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "SIMULATION PASSED" "$LOG"; then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi

// File: test/tb_timer_bus.svh
`ifndef TB_TIMER_BUS_SVH
`define TB_TIMER_BUS_SVH

localparam int ACK_TIMEOUT = 20;	// cycles

// numerical recipes constants
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

task automatic check_value(input string what, input bus_data_t expected,
		input bus_data_t actual);
	if (expected !== actual) begin
		stop_with_failure($sformatf("error at %0t: %s expected %h got %h",
			$time, what, expected, actual));
	end
endtask

// starts and ends 1 ns after a rising edge
task automatic idle_cycles(input int count);
	repeat (count) begin
		@(posedge clk);
		#1;
	end
endtask

// one wishbone classic access with stb held until ack
task automatic bus_access(input logic write_en, input bus_addr_t addr,
		input bus_data_t wdata, output bus_data_t rdata);
	int waited;
	waited = 0;
	bus_req = '{stb: 1'b1, we: write_en, adr: addr, dat: wdata};
	do begin
		@(posedge clk);
		#1;
		waited++;
		if (waited > ACK_TIMEOUT && !bus_rsp.ack) begin
			stop_with_failure($sformatf("bus access to word %0d got no ack within %0d cycles",
				addr, ACK_TIMEOUT));
		end
	end while (!bus_rsp.ack);
	check_value("ack latency", 1, waited);
	rdata          = bus_rsp.dat;	// valid while ack is high
	last_ack_cycle = cycle_cnt;
	bus_req.stb    = 1'b0;
	bus_req.we     = 1'b0;
	idle_cycles(1);	// stb low for a full cycle
	check_value("ack after one cycle", 0, bus_rsp.ack);
endtask

task automatic wait_irq(input logic level, input int limit);
	int waited;
	waited = 0;
	while (irq !== level) begin
		if (waited >= limit) begin
			stop_with_failure($sformatf("irq did not reach %0b within %0d cycles",
				level, limit));
		end
		@(posedge clk);
		#1;
		waited++;
	end
endtask

`endif

// File: test/tb_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_timer;

	import bus_pkg::*;
	import timer_pkg::*;

	localparam int        COUNTER_WIDTH = 32;
	localparam bus_data_t CNT_MASK      = bus_data_t'((64'd1 << COUNTER_WIDTH) - 1);

	logic        clk;
	logic        reset;
	wb_req_t     bus_req;
	wb_rsp_t     bus_rsp;
	logic        irq;
	int          cycle_cnt = 0;	// free running edge count for elapsed time
	int          last_ack_cycle;
	logic [31:0] lcg_state;

	// register map model
	bus_data_t   ref_ctrl;
	logic        ref_isr;
	bus_data_t   ref_count;
	bus_data_t   ref_cmp;

	timer_top #(
		.COUNTER_WIDTH (COUNTER_WIDTH)
	) u_timer_top (
		.clk       (clk),
		.reset     (reset),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.irq_o     (irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	`include "tb_timer_bus.svh"

	task automatic reset_model();
		ref_ctrl  = '0;
		ref_isr   = 1'b0;
		ref_count = '0;
		ref_cmp   = CNT_MASK;	// compare resets to all ones
	endtask

	task automatic update_model(input bus_addr_t addr, input bus_data_t wdata);
		case (addr)
			ADDR_TCSR: begin
				ref_ctrl = wdata & 32'h7D;	// bits 6..2 and enable
				if (wdata[7] || !wdata[2]) begin
					ref_isr = 1'b0;	// write one or int_en low clears
				end
			end
			ADDR_COUNT: ref_count = wdata & CNT_MASK;
			ADDR_CMP:   ref_cmp = wdata & CNT_MASK;
			default:    ;
		endcase
	endtask

	// expected readback for any word address
	function automatic bus_data_t expected_read(input bus_addr_t addr);
		bus_data_t value;
		value = '0;
		case (addr)
			ADDR_TCSR: begin
				value[7]   = ref_isr;
				value[6:2] = ref_ctrl[6:2];
				value[0]   = ref_ctrl[0];	// bit 1 stays zero
			end
			ADDR_COUNT: value = ref_count;
			ADDR_CMP:   value = ref_cmp;
			default:    value = '0;
		endcase
		return value;
	endfunction

	task automatic write_reg(input bus_addr_t addr, input bus_data_t wdata);
		bus_data_t unused;
		bus_access(1'b1, addr, wdata, unused);
		update_model(addr, wdata);
	endtask

	task automatic read_check(input string what, input bus_addr_t addr);
		bus_data_t value;
		bus_access(1'b0, addr, '0, value);
		check_value(what, expected_read(addr), value);
	endtask

	task automatic read_reset_values();
		read_check("tcsr after reset", ADDR_TCSR);
		read_check("count after reset", ADDR_COUNT);
		read_check("compare after reset", ADDR_CMP);
		check_value("irq after reset", 0, irq);
	endtask

	task automatic sweep_readback();
		bus_addr_t addr;
		for (int i = 0; i < 8; i++) begin
			write_reg(ADDR_TCSR, lcg_next() & ~32'h1);	// timer stays stopped
			write_reg(ADDR_CMP, lcg_next());
			write_reg(ADDR_COUNT, lcg_next());
			read_check("tcsr readback", ADDR_TCSR);
			read_check("compare readback", ADDR_CMP);
			read_check("count readback", ADDR_COUNT);
		end
		for (int a = 3; a < 8; a++) begin
			addr = bus_addr_t'(a);
			write_reg(addr, lcg_next());
			read_check("unmapped address", addr);
		end
		read_check("tcsr after unmapped writes", ADDR_TCSR);
		read_check("compare after unmapped writes", ADDR_CMP);
	endtask

	task automatic measure_count_rate();
		div_sel_t  div;
		bus_data_t value;
		bus_data_t expected;
		bus_data_t near;
		int        start_cycle;
		int        elapsed;
		for (int i = 0; i < 4; i++) begin
			div = div_sel_t'(lcg_next() >> 20);
			write_reg(ADDR_TCSR, '0);
			write_reg(ADDR_COUNT, '0);
			write_reg(ADDR_TCSR, bus_data_t'({div, 4'b0001}));
			start_cycle = last_ack_cycle;
			idle_cycles(300 + i * 97);
			bus_access(1'b0, ADDR_COUNT, '0, value);
			elapsed  = last_ack_cycle - start_cycle;
			expected = bus_data_t'(elapsed >> div);
			// one tick of slack either way
			near = (value + 1 == expected || value == expected + 1) ? expected : value;
			check_value("count rate", expected, near);
		end
		write_reg(ADDR_TCSR, '0);
	endtask

	task automatic watch_compare_reset();
		bus_data_t value;
		logic      seen_five;
		logic      wrapped;
		int        reads;
		seen_five = 1'b0;
		wrapped   = 1'b0;
		reads     = 0;
		write_reg(ADDR_CMP, 32'd5);
		write_reg(ADDR_COUNT, '0);
		write_reg(ADDR_TCSR, 32'h09);	// rst_on_cmp and enable with div 0
		while (!wrapped && reads < 100) begin
			bus_access(1'b0, ADDR_COUNT, '0, value);
			check_value("count above compare", 1, value <= 32'd5);
			if (value == 5) begin
				seen_five = 1'b1;
			end else if (seen_five && value < 5) begin
				wrapped = 1'b1;
			end
			idle_cycles(reads % 5);	// uneven gaps cover every phase
			reads++;
		end
		check_value("wrap after compare", 1, wrapped);
		write_reg(ADDR_TCSR, '0);
	endtask

	task automatic exercise_interrupt();
		write_reg(ADDR_CMP, 32'd5);
		write_reg(ADDR_COUNT, '0);
		write_reg(ADDR_TCSR, 32'h0D);	// int_en with rst_on_cmp and enable
		wait_irq(1'b1, 50);
		ref_isr = 1'b1;
		read_check("tcsr with flag set", ADDR_TCSR);
		write_reg(ADDR_TCSR, 32'h04);	// stop the timer while the flag stays
		check_value("irq held while stopped", 1, irq);
		write_reg(ADDR_TCSR, 32'h84);
		check_value("irq after clear", 0, irq);
		read_check("tcsr after clear", ADDR_TCSR);
		write_reg(ADDR_COUNT, '0);
		write_reg(ADDR_TCSR, 32'h09);
		// three compare periods of six clocks
		for (int i = 0; i < 20; i++) begin
			check_value("irq with int_en clear", 0, irq);
			idle_cycles(1);
		end
	endtask

	initial begin
		reset     = 1'b1;
		bus_req   = '0;
		lcg_state = 32'h8244;
		reset_model();
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		idle_cycles(2);
		read_reset_values();
		sweep_readback();
		measure_count_rate();
		watch_compare_reset();
		exercise_interrupt();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: timer/timer_counter.sv
`timescale 1ns/1ps
`default_nettype none

module timer_counter #(
	parameter int COUNTER_WIDTH = timer_pkg::COUNT_WIDTH_DEF
) (
	input  wire                          clk,
	input  wire                          reset,
	input  wire timer_pkg::timer_ctrl_t  ctrl_i,
	input  wire                          tick_i,	// from the prescaler
	output logic [COUNTER_WIDTH-1:0]     count_o,
	output logic                         match_o	// back to the register block
);

	logic [COUNTER_WIDTH-1:0] count_q;
	logic [COUNTER_WIDTH-1:0] cmp_val;
	logic [COUNTER_WIDTH-1:0] load_val;

	// control struct is full width, only the low bits matter here
	assign cmp_val  = ctrl_i.cmp_value[COUNTER_WIDTH-1:0];
	assign load_val = ctrl_i.load_value[COUNTER_WIDTH-1:0];

	// only a tick can raise match
	assign match_o = tick_i & (count_q == cmp_val);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count_q <= '0;
		end else if (ctrl_i.load_valid) begin
			count_q <= load_val;	// bus load wins over a tick
		end else if (tick_i) begin
			if (match_o && ctrl_i.rst_on_cmp) begin
				count_q <= '0;
			end else begin
				count_q <= count_q + 1'b1;	// wraps at full scale
			end
		end
	end

	assign count_o = count_q;

endmodule

`default_nettype wire

// File: timer/timer_prescaler.sv
`timescale 1ns/1ps
`default_nettype none

module timer_prescaler (
	input  wire                          clk,
	input  wire                          reset,
	input  wire timer_pkg::timer_ctrl_t  ctrl_i,
	output logic                         tick_o	// one cycle every 2**div_sel clocks
);

	import timer_pkg::*;

	div_cnt_t one_hot;
	div_cnt_t terminal;
	div_cnt_t div_q;
	logic     wrap;

	// 1 << div_sel, which drops out to zero for div_sel 7
	assign one_hot = div_cnt_t'(1) << ctrl_i.div_sel;

	// one less gives the terminal count, zero wraps round to 127
	assign terminal = one_hot - 1'b1;

	// >= so a smaller div_sel written mid count still wraps at once
	assign wrap = (div_q >= terminal);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			div_q <= '0;
		end else if (!ctrl_i.enable) begin
			div_q <= '0;	// restart from zero on every enable
		end else if (wrap) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	assign tick_o = ctrl_i.enable & wrap;

endmodule

`default_nettype wire

// File: timer/timer_regs.sv
`timescale 1ns/1ps
`default_nettype none

module timer_regs #(
	parameter int COUNTER_WIDTH = timer_pkg::COUNT_WIDTH_DEF
) (
	input  wire                          clk,
	input  wire                          reset,
	input  wire bus_pkg::wb_req_t        bus_req_i,
	output bus_pkg::wb_rsp_t             bus_rsp_o,
	input  wire [COUNTER_WIDTH-1:0]      count_i,	// live count for readback
	input  wire                          match_i,	// compare hit on a tick
	output timer_pkg::timer_ctrl_t       ctrl_o,
	output logic                         irq_o
);

	import bus_pkg::*;
	import timer_pkg::*;

	logic                     ack_q;
	logic                     accept;
	logic                     wr_tcsr;
	logic                     wr_count;
	logic                     wr_cmp;
	logic                     rd_req;
	tcsr_t                    wr_ctrl;
	tcsr_t                    tcsr_rd;
	logic                     enable_q;
	div_sel_t                 div_sel_q;
	logic                     rst_on_cmp_q;
	logic                     int_en_q;
	logic                     isr_q;
	logic [COUNTER_WIDTH-1:0] cmp_q;
	logic                     load_valid_q;
	count_t                   load_value_q;
	bus_data_t                rd_next;
	bus_data_t                rd_q;

	// a request is taken on any edge with stb high and ack low
	assign accept   = bus_req_i.stb & ~ack_q;
	assign wr_tcsr  = accept & bus_req_i.we & (bus_req_i.adr == ADDR_TCSR);
	assign wr_count = accept & bus_req_i.we & (bus_req_i.adr == ADDR_COUNT);
	assign wr_cmp   = accept & bus_req_i.we & (bus_req_i.adr == ADDR_CMP);
	assign rd_req   = accept & ~bus_req_i.we;

	assign wr_ctrl = tcsr_t'(bus_req_i.dat[$bits(tcsr_t)-1:0]);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q        <= 1'b0;
			enable_q     <= 1'b0;
			div_sel_q    <= '0;
			rst_on_cmp_q <= 1'b0;
			int_en_q     <= 1'b0;
			isr_q        <= 1'b0;
			cmp_q        <= '1;	// no match until software sets one
			load_valid_q <= 1'b0;
		end else begin
			ack_q        <= accept;	// single cycle ack
			load_valid_q <= wr_count;
			if (wr_tcsr) begin
				enable_q     <= wr_ctrl.enable;
				div_sel_q    <= wr_ctrl.div_sel;
				rst_on_cmp_q <= wr_ctrl.rst_on_cmp;
				int_en_q     <= wr_ctrl.int_en;
			end
			if (wr_cmp) begin
				cmp_q <= bus_req_i.dat[COUNTER_WIDTH-1:0];
			end
			// set beats clear when both land in the same cycle
			if (match_i && int_en_q) begin
				isr_q <= 1'b1;
			end else if (!int_en_q || (wr_tcsr && wr_ctrl.isr)) begin
				isr_q <= 1'b0;
			end
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (wr_count) begin
			load_value_q <= bus_req_i.dat;
		end
		if (rd_req) begin
			rd_q <= rd_next;
		end
	end

	assign tcsr_rd = '{
		isr:        isr_q,
		div_sel:    div_sel_q,
		rst_on_cmp: rst_on_cmp_q,
		int_en:     int_en_q,
		rsvd:       1'b0,
		enable:     enable_q
	};

	always_comb begin
		rd_next = '0;	// unmapped words read zero
		case (bus_req_i.adr)
			ADDR_TCSR:  rd_next[$bits(tcsr_t)-1:0] = tcsr_rd;
			ADDR_COUNT: rd_next[COUNTER_WIDTH-1:0] = count_i;
			ADDR_CMP:   rd_next[COUNTER_WIDTH-1:0] = cmp_q;
			default:    rd_next = '0;
		endcase
	end

	assign bus_rsp_o = '{ack: ack_q, dat: rd_q};

	assign ctrl_o = '{
		enable:     enable_q,
		div_sel:    div_sel_q,
		rst_on_cmp: rst_on_cmp_q,
		load_valid: load_valid_q,
		load_value: load_value_q,
		cmp_value:  count_t'(cmp_q)
	};

	assign irq_o = isr_q;

endmodule

`default_nettype wire
